//--- rtl/videoTiming_config.svh
// raster geometry for the video transmitter
// plus how far the pixel request leads the display window
`ifndef VIDEO_TIMING_CONFIG_SVH
`define VIDEO_TIMING_CONFIG_SVH

////////////////////////////////////////////////////////////
// horizontal, in clk cycles
////////////////////////////////////////////////////////////
`define H_SYNC   4
`define H_BACK   4
`define H_DISP   16
`define H_FRONT  4
`define H_TOTAL  (`H_SYNC + `H_BACK + `H_DISP + `H_FRONT)    // 28

////////////////////////////////////////////////////////////
// vertical, in lines
////////////////////////////////////////////////////////////
`define V_SYNC   2
`define V_BACK   2
`define V_DISP   4
`define V_FRONT  2
`define V_TOTAL  (`V_SYNC + `V_BACK + `V_DISP + `V_FRONT)    // 10

// request lead ahead of the display window
// the external source answers one cycle after the request
`define REQ_AHEAD 1

`endif

//--- rtl/videoPkg.sv
// raster coordinate and colour types shared by the pixel path
`default_nettype none

package videoPkg;

    ////////////////////////////////////////////////////////////
    // raster position
    ////////////////////////////////////////////////////////////
    typedef logic [15:0] coordT;    // unsigned counter value

    ////////////////////////////////////////////////////////////
    // colour
    ////////////////////////////////////////////////////////////
    typedef logic [7:0] colorT;     // one component

    // red sits in the top byte, blue in the bottom one
    typedef struct packed
    {
        colorT red;
        colorT green;
        colorT blue;
    } rgbT;

endpackage

`default_nettype wire

//--- rtl/tmdsPkg.sv
// TMDS symbol and control pair types
// the four control symbols sent during blanking
`default_nettype none

package tmdsPkg;

    ////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////
    typedef logic [9:0] symbolT;    // bit 0 goes out first

    // {c1, c0}, blue carries {vSync, hSync}
    typedef logic [1:0] ctrlT;

    ////////////////////////////////////////////////////////////
    // control symbols
    ////////////////////////////////////////////////////////////
    // each has many transitions so the receiver can lock
    // onto symbol boundaries during blanking
    localparam symbolT CTRL00 = 10'b1101010100;
    localparam symbolT CTRL01 = 10'b0010101011;
    localparam symbolT CTRL10 = 10'b0101010100;
    localparam symbolT CTRL11 = 10'b1010101011;

endpackage

`default_nettype wire

//--- rtl/videoTiming.sv
// raster counters, registered sync pulses and display enable
// and the early pixel request toward the external source
`default_nettype none
`timescale 1ns/1ps
`include "videoTiming_config.svh"

module videoTiming
(
    input  wire logic       clk,
    input  wire logic       rstn,
    output logic            pixelReq,
    output logic            hSync,
    output logic            vSync,
    output logic            de,
    output videoPkg::coordT pixelX,
    output videoPkg::coordT pixelY
);
    import videoPkg::*;

    // window edges, end values are exclusive
    localparam coordT hSyncEnd   = coordT'(`H_SYNC);
    localparam coordT hDispStart = coordT'(`H_SYNC + `H_BACK);
    localparam coordT hDispEnd   = coordT'(`H_SYNC + `H_BACK + `H_DISP);
    localparam coordT hReqStart  = coordT'(`H_SYNC + `H_BACK - `REQ_AHEAD);
    localparam coordT hReqEnd    = coordT'(`H_SYNC + `H_BACK + `H_DISP - `REQ_AHEAD);
    localparam coordT hLast      = coordT'(`H_TOTAL - 1);
    localparam coordT vSyncEnd   = coordT'(`V_SYNC);
    localparam coordT vDispStart = coordT'(`V_SYNC + `V_BACK);
    localparam coordT vDispEnd   = coordT'(`V_SYNC + `V_BACK + `V_DISP);
    localparam coordT vLast      = coordT'(`V_TOTAL - 1);

    coordT xPos;
    coordT yPos;
    logic  xWrap;
    logic  yWrap;
    logic  xInDisp;
    logic  xInReq;
    logic  yInDisp;

    assign xWrap   = (xPos == hLast);
    assign yWrap   = (yPos == vLast);
    assign xInDisp = (xPos >= hDispStart) && (xPos < hDispEnd);
    assign xInReq  = (xPos >= hReqStart) && (xPos < hReqEnd);
    assign yInDisp = (yPos >= vDispStart) && (yPos < vDispEnd);

    // same test as de, shifted earlier by the lead
    assign pixelReq = xInReq && yInDisp;

    ////////////////////////////////////////////////////////////
    // raster counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            xPos <= '0;
            yPos <= '0;
        end
        else
        begin
            xPos <= xWrap ? '0 : xPos + 16'd1;
            if (xWrap)
                yPos <= yWrap ? '0 : yPos + 16'd1;    // one line done
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs, one cycle behind the counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            hSync  <= 1'b0;
            vSync  <= 1'b0;
            de     <= 1'b0;
            pixelX <= '0;
            pixelY <= '0;
        end
        else
        begin
            hSync  <= (xPos < hSyncEnd);    // active high inside sync span
            vSync  <= (yPos < vSyncEnd);
            de     <= xInDisp && yInDisp;
            pixelX <= xPos;                 // coordinates of the de cycle
            pixelY <= yPos;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pixelSource.sv
// pixel source, registers the external colour or a built-in
// diagonal-and-square test pattern
`default_nettype none
`timescale 1ns/1ps

module pixelSource
(
    input  wire logic            clk,
    input  wire logic            rstn,
    input  wire logic            patternEn,
    input  wire videoPkg::rgbT   pixelRgb,
    input  wire videoPkg::coordT pixelX,
    input  wire videoPkg::coordT pixelY,
    output videoPkg::rgbT        rgbOut
);
    import videoPkg::*;

    coordT patX;     // x of the pixel being registered
    colorT diag;     // W, on the x == y diagonal
    colorT square;   // A, inside the small square
    rgbT   pattern;

    // pixelX is one cycle behind the counters, so the pixel
    // registered now shows up with pixelX one higher
    assign patX = pixelX + 16'd1;

    assign diag   = {8{patX[7:0] == pixelY[7:0]}};
    assign square = {8{(patX[7:5] == 3'd2) && (pixelY[7:5] == 3'd2)}};

    // white diagonal, blue square
    assign pattern.red   = diag;
    assign pattern.green = diag;
    assign pattern.blue  = diag | square;

    ////////////////////////////////////////////////////////////
    // output register, valid together with de
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            rgbOut <= '0;
        else if (patternEn)
            rgbOut <= pattern;
        else
            rgbOut <= pixelRgb;    // answer to last cycle's request
    end

endmodule

`default_nettype wire

//--- rtl/tmdsEncoder.sv
// one TMDS channel encoder: transition minimising, DC balance,
// control symbols during blanking
`default_nettype none
`timescale 1ns/1ps

module tmdsEncoder
(
    input  wire logic           clk,
    input  wire logic           rstn,
    input  wire videoPkg::colorT dataIn,
    input  wire tmdsPkg::ctrlT  ctrlIn,
    input  wire logic           de,
    output tmdsPkg::symbolT     symbol
);
    import tmdsPkg::*;

    logic [3:0]        onesIn;
    logic              useXnor;
    logic [8:0]        qm;           // bit 8 set when XOR was used
    logic [3:0]        onesQm;
    logic signed [5:0] diffQm;       // ones minus zeros of qm[7:0]
    logic signed [5:0] disparity;    // running, cleared in blanking
    logic signed [5:0] dispNext;
    logic              invert;
    symbolT            dataSym;
    symbolT            ctrlSym;

    ////////////////////////////////////////////////////////////
    // transition minimising stage
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        onesIn = '0;
        for (int i = 0; i < 8; i++)
            onesIn = onesIn + {3'b000, dataIn[i]};
        useXnor = (onesIn > 4'd4) || ((onesIn == 4'd4) && !dataIn[0]);
        qm[0] = dataIn[0];
        for (int i = 1; i < 8; i++)
            qm[i] = useXnor ? ~(qm[i-1] ^ dataIn[i]) : (qm[i-1] ^ dataIn[i]);
        qm[8] = ~useXnor;
    end

    ////////////////////////////////////////////////////////////
    // DC balance stage
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        onesQm = '0;
        for (int i = 0; i < 8; i++)
            onesQm = onesQm + {3'b000, qm[i]};
        diffQm = $signed({1'b0, onesQm, 1'b0}) - 6'sd8;
        if ((disparity == 6'sd0) || (diffQm == 6'sd0))
        begin
            invert   = ~qm[8];    // neutral case, bit 9 mirrors bit 8
            dispNext = qm[8] ? disparity + diffQm : disparity - diffQm;
        end
        else if (disparity[5] == diffQm[5])
        begin
            // same sign would drift further, so invert
            invert   = 1'b1;
            dispNext = disparity - diffQm + (qm[8] ? 6'sd2 : 6'sd0);
        end
        else
        begin
            invert   = 1'b0;
            dispNext = disparity + diffQm - (qm[8] ? 6'sd0 : 6'sd2);
        end
        dataSym = {invert, qm[8], qm[7:0] ^ {8{invert}}};
    end

    always_comb
    begin
        case (ctrlIn)
            2'b00:   ctrlSym = CTRL00;
            2'b01:   ctrlSym = CTRL01;
            2'b10:   ctrlSym = CTRL10;
            default: ctrlSym = CTRL11;
        endcase
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            symbol    <= '0;
            disparity <= '0;
        end
        else if (de)
        begin
            symbol    <= dataSym;
            disparity <= dispNext;
        end
        else
        begin
            symbol    <= ctrlSym;
            disparity <= '0;    // restart each line
        end
    end

endmodule

`default_nettype wire

//--- rtl/tmdsSerializer.sv
// 10:2 shifter for three TMDS channels on the 5x clock
// each channel presents a DDR bit pair per fast cycle
`default_nettype none
`timescale 1ns/1ps

module tmdsSerializer
(
    input  wire logic            clkTmds,
    input  wire logic            rstn,
    input  wire tmdsPkg::symbolT symR,
    input  wire tmdsPkg::symbolT symG,
    input  wire tmdsPkg::symbolT symB,
    output logic [1:0]           pairR,
    output logic [1:0]           pairG,
    output logic [1:0]           pairB
);
    import tmdsPkg::*;

    logic [2:0] phase;          // mod 5, one symbol per wrap
    logic       load;
    symbolT     symIn [3];      // 0 red, 1 green, 2 blue
    symbolT     shiftReg [3];

    assign symIn[0] = symR;
    assign symIn[1] = symG;
    assign symIn[2] = symB;

    assign load = (phase == 3'd4);

    ////////////////////////////////////////////////////////////
    // phase counter and load-or-shift registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clkTmds or negedge rstn)
    begin
        if (!rstn)
        begin
            phase <= '0;
            for (int i = 0; i < 3; i++)
                shiftReg[i] <= '0;
        end
        else
        begin
            phase <= load ? 3'd0 : phase + 3'd1;
            for (int i = 0; i < 3; i++)
                shiftReg[i] <= load ? symIn[i] : {2'b00, shiftReg[i][9:2]};
        end
    end

    // lsb pair first, bit 0 on the first half of the fast cycle
    assign pairR = shiftReg[0][1:0];
    assign pairG = shiftReg[1][1:0];
    assign pairB = shiftReg[2][1:0];

endmodule

`default_nettype wire

//--- rtl/hdmiTx.sv
// video transmitter top with timing, pixel source, three TMDS
// encoders and the DDR-pair serializer
`default_nettype none
`timescale 1ns/1ps

module hdmiTx
(
    input  wire logic          clk,
    input  wire logic          clkTmds,    // 5x clk and edge aligned
    input  wire logic          rstn,
    input  wire logic          patternEn,
    output logic               pixelReq,
    input  wire videoPkg::rgbT pixelRgb,   // one cycle after pixelReq
    output logic [1:0]         pairR,
    output logic [1:0]         pairG,
    output logic [1:0]         pairB
);
    import videoPkg::*;
    import tmdsPkg::*;

    logic   hSync;
    logic   vSync;
    logic   de;
    coordT  pixelX;
    coordT  pixelY;
    rgbT    rgb;
    ctrlT   ctrlSync;
    symbolT symR;
    symbolT symG;
    symbolT symB;

    assign ctrlSync = {vSync, hSync};

    ////////////////////////////////////////////////////////////
    // pixel clock domain
    ////////////////////////////////////////////////////////////
    videoTiming timing0
    (
        .clk(clk), .rstn(rstn), .pixelReq(pixelReq),
        .hSync(hSync), .vSync(vSync), .de(de),
        .pixelX(pixelX), .pixelY(pixelY)
    );

    pixelSource src0
    (
        .clk(clk), .rstn(rstn), .patternEn(patternEn), .pixelRgb(pixelRgb),
        .pixelX(pixelX), .pixelY(pixelY), .rgbOut(rgb)
    );

    // red and green carry no control
    tmdsEncoder encR
    (
        .clk(clk), .rstn(rstn), .dataIn(rgb.red), .ctrlIn(2'b00),
        .de(de), .symbol(symR)
    );

    tmdsEncoder encG
    (
        .clk(clk), .rstn(rstn), .dataIn(rgb.green), .ctrlIn(2'b00),
        .de(de), .symbol(symG)
    );

    tmdsEncoder encB
    (
        .clk(clk), .rstn(rstn), .dataIn(rgb.blue), .ctrlIn(ctrlSync),
        .de(de), .symbol(symB)
    );

    ////////////////////////////////////////////////////////////
    // fast clock domain
    ////////////////////////////////////////////////////////////
    tmdsSerializer ser0
    (
        .clkTmds(clkTmds), .rstn(rstn),
        .symR(symR), .symG(symG), .symB(symB),
        .pairR(pairR), .pairG(pairG), .pairB(pairB)
    );

endmodule

`default_nettype wire

//--- test/hdmiTxTb.sv
// video transmitter testbench with clocks, reset, pixel source model
// symbol deserializer and raster model checks
`default_nettype none
`timescale 1ns/1ps
`include "videoTiming_config.svh"

module hdmiTxTb;
    import tmdsPkg::*;

    localparam int hDispStart  = `H_SYNC + `H_BACK;
    localparam int vDispStart  = `V_SYNC + `V_BACK;
    localparam int frameLen    = `H_TOTAL * `V_TOTAL;
    localparam int numFrames   = 3;
    localparam int pixPerFrame = `H_DISP * `V_DISP;
    localparam int cycleLimit  = 16 + numFrames * frameLen + 200;

    logic        clk       = 1'b0;
    logic        clkTmds   = 1'b0;
    logic        rstn      = 1'b0;
    logic        patternEn = 1'b0;
    logic [23:0] pixelRgb  = '0;
    logic        pixelReq;
    logic [1:0]  pairR;
    logic [1:0]  pairG;
    logic [1:0]  pairB;

    logic [59:0] stim [0:66];    // 64 pixels then one flag per frame
    integer      seed       = 32'h8c95;
    int          cycles     = 0;
    int          pos        = 0;    // raster position since reset
    int          reqIdx     = 0;
    int          reqInFrame = 0;
    symbolT      winR       = '0;
    symbolT      winG       = '0;
    symbolT      winB       = '0;
    logic        aligned    = 1'b0;
    logic        started    = 1'b0;
    logic        done       = 1'b0;
    int          pairCnt    = 0;
    int          symIdx     = 0;
    int          balR       = 0;
    int          balG       = 0;
    int          balB       = 0;

    always #2 clk = ~clk;
    always #0.4 clkTmds = ~clkTmds;    // 5x rate with edges on clk edges

    hdmiTx dut0
    (
        .clk(clk), .clkTmds(clkTmds), .rstn(rstn), .patternEn(patternEn),
        .pixelReq(pixelReq), .pixelRgb(pixelRgb),
        .pairR(pairR), .pairG(pairG), .pairB(pairB)
    );

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want)
        begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, want);
            $display("TESTS FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic symbolT ctrlFor(input logic vs, input logic hs);
        case ({vs, hs})
            2'b00:   return CTRL00;
            2'b01:   return CTRL01;
            2'b10:   return CTRL10;
            default: return CTRL11;
        endcase
    endfunction

    // ones minus zeros of a whole symbol
    function automatic int balanceOf(input symbolT s);
        int n;
        n = 0;
        for (int k = 0; k < 10; k++)
            n = n + (s[k] ? 1 : -1);
        return n;
    endfunction

    // undo the inversion, then the xor or xnor chain
    function automatic logic [7:0] decodeSym(input symbolT s);
        logic [7:0] d;
        logic [7:0] q;
        d = s[9] ? ~s[7:0] : s[7:0];
        q[0] = d[0];
        for (int k = 1; k < 8; k++)
            q[k] = s[8] ? (d[k] ^ d[k-1]) : ~(d[k] ^ d[k-1]);
        return q;
    endfunction

    function automatic logic [23:0] patternColor(input int x, input int y);
        logic [15:0] xc;
        logic [15:0] yc;
        logic [7:0]  w;
        logic [7:0]  a;
        xc = 16'(x);
        yc = 16'(y);
        w = (xc[7:0] == yc[7:0]) ? 8'hFF : 8'h00;                       // diagonal
        a = ((xc[7:5] == 3'd2) && (yc[7:5] == 3'd2)) ? 8'hFF : 8'h00;   // square
        return {w, w, w | a};
    endfunction

    ////////////////////////////////////////////////////////////
    // one framed symbol per channel against the raster model
    ////////////////////////////////////////////////////////////
    task automatic takeSymbol();
        int          f;
        int          p;
        int          x;
        int          y;
        int          i;
        logic [23:0] want;
        if (!started && winB == CTRL11)
            started = 1'b1;    // blue shows vsync and hsync at raster (0,0)
        if (started && !done)
        begin
            f = symIdx / frameLen;
            p = symIdx % frameLen;
            x = p % `H_TOTAL;
            y = p / `H_TOTAL;
            if (x >= hDispStart && x < hDispStart + `H_DISP &&
                y >= vDispStart && y < vDispStart + `V_DISP)
            begin
                i = (y - vDispStart) * `H_DISP + (x - hDispStart);
                if (stim[7'(pixPerFrame + f)][0] == 1'b0)
                begin
                    checkValue("red symbol", 32'(winR), 32'(stim[7'(i)][33:24]));
                    checkValue("green symbol", 32'(winG), 32'(stim[7'(i)][21:12]));
                    checkValue("blue symbol", 32'(winB), 32'(stim[7'(i)][9:0]));
                end
                else
                begin
                    want = patternColor(x, y);
                    checkValue("decoded red", 32'(decodeSym(winR)), 32'(want[23:16]));
                    checkValue("decoded green", 32'(decodeSym(winG)), 32'(want[15:8]));
                    checkValue("decoded blue", 32'(decodeSym(winB)), 32'(want[7:0]));
                end
                balR = balR + balanceOf(winR);
                balG = balG + balanceOf(winG);
                balB = balB + balanceOf(winB);
                checkValue("red balance in range", 32'(balR >= -8 && balR <= 8), 32'd1);
                checkValue("green balance in range", 32'(balG >= -8 && balG <= 8), 32'd1);
                checkValue("blue balance in range", 32'(balB >= -8 && balB <= 8), 32'd1);
            end
            else
            begin
                balR = 0;    // restarts each line
                balG = 0;
                balB = 0;
                checkValue("red symbol", 32'(winR), 32'(CTRL00));
                checkValue("green symbol", 32'(winG), 32'(CTRL00));
                checkValue("blue symbol", 32'(winB),
                           32'(ctrlFor(y < `V_SYNC, x < `H_SYNC)));
            end
            symIdx = symIdx + 1;
            if (symIdx == numFrames * frameLen)
                done = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // external source, request checks and timeout
    ////////////////////////////////////////////////////////////
    always @(posedge clk)
    begin
        logic [31:0] rnd;
        logic        reqWant;
        int          f;
        int          x;
        int          y;
        cycles = cycles + 1;
        if (cycles >= cycleLimit)
        begin
            $display("timeout: the expected symbols never completed");
            $display("TESTS FAILED");
            $fatal(1, "simulation timed out");
        end
        else if (!rstn)
            checkValue("pixelReq", 32'(pixelReq), 32'd0);
        else
        begin
            f = pos / frameLen;
            if (f > numFrames - 1)
                f = numFrames - 1;
            x = pos % `H_TOTAL;
            y = (pos / `H_TOTAL) % `V_TOTAL;
            if (pos % frameLen == 0)
            begin
                patternEn  <= stim[7'(pixPerFrame + f)][0];
                reqIdx     = 0;
                reqInFrame = 0;
            end
            reqWant = (x >= hDispStart - `REQ_AHEAD) &&
                      (x < hDispStart + `H_DISP - `REQ_AHEAD) &&
                      (y >= vDispStart) && (y < vDispStart + `V_DISP);
            checkValue("pixelReq", 32'(pixelReq), 32'(reqWant));
            if (pixelReq)
            begin
                if (stim[7'(pixPerFrame + f)][0])
                begin
                    rnd = $random(seed);    // ignored by the DUT in pattern mode
                    pixelRgb <= rnd[23:0];
                end
                else
                    pixelRgb <= stim[7'(reqIdx)][59:36];
                reqIdx     = (reqIdx + 1) % pixPerFrame;
                reqInFrame = reqInFrame + 1;
            end
            if (pos % frameLen == frameLen - 1)
                checkValue("requests per frame", 32'(reqInFrame), 32'(pixPerFrame));
            pos = pos + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // deserializer taking the lsb pair first
    ////////////////////////////////////////////////////////////
    always @(negedge clkTmds)
    begin
        if (!rstn)
        begin
            checkValue("pairR", 32'(pairR), 32'd0);
            checkValue("pairG", 32'(pairG), 32'd0);
            checkValue("pairB", 32'(pairB), 32'd0);
        end
        else if (!done)
        begin
            winR = {pairR, winR[9:2]};
            winG = {pairG, winG[9:2]};
            winB = {pairB, winB[9:2]};
            if (!aligned)
            begin
                if (winR == CTRL00)    // red's only blanking symbol
                begin
                    aligned = 1'b1;
                    pairCnt = 0;
                    takeSymbol();
                end
            end
            else
            begin
                pairCnt = pairCnt + 1;
                if (pairCnt == 5)
                begin
                    pairCnt = 0;
                    takeSymbol();
                end
            end
        end
    end

    initial
    begin
        $readmemh("test/hdmiStimulus.txt", stim);
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        wait (done);
        @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/hdmiStimulus.txt
// per display pixel: rgb (6 hex), then red, green, blue symbols (3 hex each)
// last three words: patternEn flag for frames 0, 1 and 2
// line 0
0010101001F01F0
1011001F010F100
0022113FF11E10F
11440010F13C3FF
00882210017811E
22550011E133100
00AA443FF23313C
44100013C1F03FF
00118810010F178
88220017811E100
0044553FF13C133
5588001331783FF
0055AA100133233
AAAA00233233100
0010103FF1F01F0
1011001F010F3FF
// line 1
00114410010F13C
11220010F11E100
0044883FF13C178
22880011E1783FF
005555100133133
44AA0013C233100
0010AA3FF1F0233
88110017810F3FF
00221010011E1F0
55440013313C100
0088113FF17810F
AA55002331333FF
00AA2210023311E
1010001F01F0100
0011443FF10F13C
11220010F11E3FF
// line 2
0022AA10011E233
22440011E13C100
0088103FF1781F0
44550013C1333FF
00AA1110023310F
8810001781F0100
0011223FF10F11E
55220013311E3FF
00444410013C13C
AA8800233178100
0055883FF133178
10AA001F02333FF
0010551001F0133
11110010F10F100
0022AA3FF11E233
22440011E13C3FF
// line 3
00442210013C11E
44880013C178100
0055443FF13313C
88AA001782333FF
0010881001F0178
55110013310F100
0022553FF11E133
AA440023313C3FF
0088AA100178233
1055001F0133100
00AA103FF2331F0
11100010F1F03FF
00111110010F10F
22220011E11E100
0044223FF13C11E
44880013C1783FF
// frame flags
0
0
1

//--- filelist.f
+incdir+rtl
rtl/videoPkg.sv
rtl/tmdsPkg.sv
rtl/videoTiming.sv
rtl/pixelSource.sv
rtl/tmdsEncoder.sv
rtl/tmdsSerializer.sv
rtl/hdmiTx.sv
test/hdmiTxTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# build the video transmitter testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f filelist.f --top-module hdmiTxTb \
    --Mdir obj_dir -o simHdmiTx

# the log decides the result, so a fatal exit must not stop the script here
./obj_dir/simHdmiTx > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
